/* hdl/cache_cfg_pkg.sv */
package cache_cfg_pkg;

    // ----------------------------------------
    // Address split
    // ----------------------------------------

    // Tag bits kept per line for the hit compare
    localparam int TAG_W = 8;
    // Selects one of the cache lines
    localparam int INDEX_W = 4;
    // Selects one word inside a line
    localparam int WORD_W = 2;
    // Full byte address seen on both buses
    localparam int ADDR_W = 16;

    // Depth of the tag array
    localparam int NUM_LINES = 16;
    // A refill moves this many words, one bus beat each
    localparam int WORDS_PER_LINE = 4;

    // The same address word read either flat or split into cache fields
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0]   tag;
            logic [INDEX_W-1:0] index;
            logic [WORD_W-1:0]  word;
            logic [1:0]         byte_off;
        } f;
    } cache_addr_u;

    // One line of the tag array
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

endpackage

/* hdl/wb_pkg.sv */
package wb_pkg;

    // ----------------------------------------
    // Wishbone classic signal groups
    // ----------------------------------------

    // Data bus width and its byte select width
    localparam int DAT_W = 32;
    localparam int SEL_W = DAT_W / 8;

    // Everything the master drives in one transfer
    // The address is the cache view so both decodings stay available
    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        cache_cfg_pkg::cache_addr_u adr;
        logic [SEL_W-1:0]          sel;
        logic [DAT_W-1:0]          dat;
    } wb_req_t;

    // Everything the slave drives back
    // Ack is high for exactly one cycle per transfer
    typedef struct packed {
        logic             ack;
        logic [DAT_W-1:0] dat;
    } wb_rsp_t;

endpackage

/* hdl/tag_memory.sv */
`timescale 1ns/1ns

module tag_memory (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    // Shared read/write port that the controller uses to install a line
    input  logic                      write_i,
    input  logic [cache_cfg_pkg::INDEX_W-1:0] read_write_index_i,
    input  cache_cfg_pkg::tag_entry_t write_tag_i,

    // Lookup port that is read every cycle
    input  logic [cache_cfg_pkg::INDEX_W-1:0] read_index_i,
    output cache_cfg_pkg::tag_entry_t read_tag_o
);

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    // Tag of each line
    logic [cache_cfg_pkg::TAG_W-1:0] tag_q [cache_cfg_pkg::NUM_LINES];

    // Valid bits of all lines in one flop vector that reset clears at once
    logic [cache_cfg_pkg::NUM_LINES-1:0] valid_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (write_i) begin
            valid_q[read_write_index_i] <= write_tag_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (write_i) begin
            tag_q[read_write_index_i] <= write_tag_i.tag;
        end
    end

    // ----------------------------------------
    // Lookup read
    // ----------------------------------------

    // The entry appears one cycle after the index
    // A write to the same line in the same cycle returns the old entry
    always_ff @(posedge clk_i) begin
        read_tag_o.valid <= valid_q[read_index_i];
        read_tag_o.tag   <= tag_q[read_index_i];
    end

    // An unknown write enable would corrupt the valid vector silently
    a_write_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(write_i));

endmodule

/* hdl/data_memory.sv */
`timescale 1ns/1ns

module data_memory (
    input  logic                              clk_i,

    // Write port, byte lanes enabled one by one
    input  logic                              write_i,
    input  logic [wb_pkg::SEL_W-1:0]          write_sel_i,
    input  logic [cache_cfg_pkg::INDEX_W-1:0] write_index_i,
    input  logic [cache_cfg_pkg::WORD_W-1:0]  write_word_i,
    input  logic [wb_pkg::DAT_W-1:0]          write_data_i,

    // Read port
    input  logic [cache_cfg_pkg::INDEX_W-1:0] read_index_i,
    input  logic [cache_cfg_pkg::WORD_W-1:0]  read_word_i,
    output logic [wb_pkg::DAT_W-1:0]          read_data_o
);

    // ----------------------------------------
    // Line storage
    // ----------------------------------------

    localparam int DEPTH = cache_cfg_pkg::NUM_LINES * cache_cfg_pkg::WORDS_PER_LINE;

    // Word address is line index on top, word in line below
    logic [wb_pkg::SEL_W-1:0][7:0] mem_q [DEPTH];

    logic [cache_cfg_pkg::INDEX_W+cache_cfg_pkg::WORD_W-1:0] write_addr;
    logic [cache_cfg_pkg::INDEX_W+cache_cfg_pkg::WORD_W-1:0] read_addr;

    assign write_addr = {write_index_i, write_word_i};
    assign read_addr  = {read_index_i, read_word_i};

    // Each byte lane is written only when its select is set
    always_ff @(posedge clk_i) begin
        if (write_i) begin
            for (int b = 0; b < wb_pkg::SEL_W; b++) begin
                if (write_sel_i[b]) begin
                    mem_q[write_addr][b] <= write_data_i[8*b +: 8];
                end
            end
        end
    end

    // Synchronous read, data follows the address by one cycle
    always_ff @(posedge clk_i) begin
        read_data_o <= mem_q[read_addr];
    end

endmodule

/* hdl/refill_counter.sv */
`timescale 1ns/1ns

module refill_counter (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             clear_i,
    input  logic                             step_i,
    output logic [cache_cfg_pkg::WORD_W-1:0] beat_o,
    output logic                             last_o
);

    // ----------------------------------------
    // Beat counter
    // ----------------------------------------

    logic [cache_cfg_pkg::WORD_W-1:0] beat_q;

    // Clear wins over step so the controller can end a refill in the
    // same cycle as the final ack
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            beat_q <= '0;
        end else if (clear_i) begin
            beat_q <= '0;
        end else if (step_i) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    assign beat_o = beat_q;

    // High for the whole final beat, not only at its ack
    assign last_o = (beat_q == cache_cfg_pkg::WORD_W'(cache_cfg_pkg::WORDS_PER_LINE - 1));

    // Stepping past the last beat would wrap into the next refill's word 0,
    // the controller must clear instead
    a_no_wrap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(step_i && last_o && !clear_i));

endmodule

/* hdl/cache_controller.sv */
`timescale 1ns/1ns

module cache_controller (
    input  logic                             clk_i,
    input  logic                             rst_n_i,

    // Processor side as Wishbone slave
    input  wb_pkg::wb_req_t                  cpu_req_i,
    output wb_pkg::wb_rsp_t                  cpu_rsp_o,

    // Memory side as Wishbone master
    output wb_pkg::wb_req_t                  mem_req_o,
    input  wb_pkg::wb_rsp_t                  mem_rsp_i,

    // Lookup results arrive one cycle behind the request address
    input  cache_cfg_pkg::tag_entry_t        tag_i,
    input  logic [wb_pkg::DAT_W-1:0]         data_i,

    // Refill beat counter
    input  logic [cache_cfg_pkg::WORD_W-1:0] beat_i,
    input  logic                             last_i,
    output logic                             cnt_clear_o,
    output logic                             cnt_step_o,

    // Tag and data memory write ports
    output logic                             tag_write_o,
    output cache_cfg_pkg::tag_entry_t        tag_entry_o,
    output logic                             data_write_o,
    output logic [wb_pkg::SEL_W-1:0]         data_sel_o,
    output logic [cache_cfg_pkg::WORD_W-1:0] data_word_o,
    output logic [wb_pkg::DAT_W-1:0]         data_wdata_o
);

    typedef enum logic [2:0] {IDLE, LOOKUP, REFILL, RESPOND, WRITE_THROUGH} state_t;

    state_t          state_q;
    wb_pkg::wb_req_t mem_req_q;
    logic            ack_q;
    logic [wb_pkg::DAT_W-1:0] rdata_q;
    logic            hit;
    logic            beat_done;

    // Valid only in LOOKUP where tag_i belongs to the held request
    assign hit = tag_i.valid && (tag_i.tag == cpu_req_i.adr.f.tag);

    // A memory transfer ends in the cycle its strobe meets the ack
    assign beat_done = mem_req_q.stb && mem_rsp_i.ack;

    // The counter is parked at zero on every lookup and cleared again at
    // the last refill ack
    assign cnt_clear_o = (state_q == LOOKUP) || (state_q == REFILL && beat_done && last_i);
    assign cnt_step_o  = (state_q == REFILL) && beat_done && !last_i;

    // ----------------------------------------
    // FSM and bus control
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q       <= IDLE;
            mem_req_q.cyc <= 1'b0;
            mem_req_q.stb <= 1'b0;
            ack_q         <= 1'b0;
            tag_write_o   <= 1'b0;
            data_write_o  <= 1'b0;
        end else begin
            // Single cycle pulses unless a state below sets them again
            ack_q       <= 1'b0;
            tag_write_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (cpu_req_i.cyc && cpu_req_i.stb) begin
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (cpu_req_i.we) begin
                        // Writes always go out and the cached copy follows only on a hit
                        state_q       <= WRITE_THROUGH;
                        mem_req_q.cyc <= 1'b1;
                        mem_req_q.stb <= 1'b1;
                        data_write_o  <= hit;
                    end else if (hit) begin
                        state_q <= IDLE;
                    end else begin
                        state_q <= REFILL;
                    end
                end
                REFILL: begin
                    data_write_o <= 1'b0;
                    if (!mem_req_q.stb) begin
                        // Next beat goes out one cycle after the previous ack
                        mem_req_q.cyc <= 1'b1;
                        mem_req_q.stb <= 1'b1;
                    end else if (mem_rsp_i.ack) begin
                        mem_req_q.cyc <= 1'b0;
                        mem_req_q.stb <= 1'b0;
                        data_write_o  <= 1'b1;
                        if (last_i) begin
                            tag_write_o <= 1'b1;
                            ack_q       <= 1'b1;
                            state_q     <= RESPOND;
                        end
                    end
                end
                WRITE_THROUGH: begin
                    // On a hit the same bytes are written in each stall cycle
                    // The final write lands with the memory ack
                    if (mem_rsp_i.ack) begin
                        mem_req_q.cyc <= 1'b0;
                        mem_req_q.stb <= 1'b0;
                        data_write_o  <= 1'b0;
                        ack_q         <= 1'b1;
                        state_q       <= RESPOND;
                    end
                end
                RESPOND: begin
                    data_write_o <= 1'b0;
                    state_q      <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Payload registers
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        case (state_q)
            LOOKUP: begin
                mem_req_q.we  <= cpu_req_i.we;
                mem_req_q.adr <= cpu_req_i.adr;
                mem_req_q.sel <= cpu_req_i.we ? cpu_req_i.sel : '1;
                mem_req_q.dat <= cpu_req_i.dat;
                tag_entry_o.valid <= 1'b1;
                tag_entry_o.tag   <= cpu_req_i.adr.f.tag;
                data_word_o  <= cpu_req_i.adr.f.word;
                data_sel_o   <= cpu_req_i.sel;
                data_wdata_o <= cpu_req_i.dat;
            end
            REFILL: begin
                if (!mem_req_q.stb) begin
                    mem_req_q.adr.f.word     <= beat_i;
                    mem_req_q.adr.f.byte_off <= '0;
                end else if (mem_rsp_i.ack) begin
                    data_word_o  <= beat_i;
                    data_sel_o   <= '1;
                    data_wdata_o <= mem_rsp_i.dat;
                    // Keep the word the processor asked for
                    if (beat_i == cpu_req_i.adr.f.word) begin
                        rdata_q <= mem_rsp_i.dat;
                    end
                end
            end
            default: ;
        endcase
    end

    assign mem_req_o = mem_req_q;

    // The hit path answers straight from the lookup and all other answers come from registers
    always_comb begin
        cpu_rsp_o.ack = ack_q || (state_q == LOOKUP && !cpu_req_i.we && hit);
        cpu_rsp_o.dat = (state_q == LOOKUP) ? data_i : rdata_q;
    end

    a_cpu_ack_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cpu_rsp_o.ack |=> !cpu_rsp_o.ack);

    // A stalled memory beat keeps every request signal until its ack
    a_mem_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o.stb && !mem_rsp_i.ack |=> $stable(mem_req_o));

endmodule

/* hdl/wb_cache_top.sv */
`timescale 1ns/1ns

module wb_cache_top (
    input  logic            clk_i,
    input  logic            rst_n_i,

    // Processor side, Wishbone slave
    input  wb_pkg::wb_req_t cpu_req_i,
    output wb_pkg::wb_rsp_t cpu_rsp_o,

    // Memory side, Wishbone master
    output wb_pkg::wb_req_t mem_req_o,
    input  wb_pkg::wb_rsp_t mem_rsp_i
);

    // ----------------------------------------
    // Internal wiring
    // ----------------------------------------

    cache_cfg_pkg::tag_entry_t        tag_rd;
    logic [wb_pkg::DAT_W-1:0]         data_rd;
    logic [cache_cfg_pkg::WORD_W-1:0] beat;
    logic                             last;
    logic                             cnt_clear;
    logic                             cnt_step;
    logic                             tag_write;
    cache_cfg_pkg::tag_entry_t        tag_entry;
    logic                             data_write;
    logic [wb_pkg::SEL_W-1:0]         data_sel;
    logic [cache_cfg_pkg::WORD_W-1:0] data_word;
    logic [wb_pkg::DAT_W-1:0]         data_wdata;

    cache_controller i_controller (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .cpu_req_i    (cpu_req_i),
        .cpu_rsp_o    (cpu_rsp_o),
        .mem_req_o    (mem_req_o),
        .mem_rsp_i    (mem_rsp_i),
        .tag_i        (tag_rd),
        .data_i       (data_rd),
        .beat_i       (beat),
        .last_i       (last),
        .cnt_clear_o  (cnt_clear),
        .cnt_step_o   (cnt_step),
        .tag_write_o  (tag_write),
        .tag_entry_o  (tag_entry),
        .data_write_o (data_write),
        .data_sel_o   (data_sel),
        .data_word_o  (data_word),
        .data_wdata_o (data_wdata)
    );

    refill_counter i_refill_counter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .clear_i (cnt_clear),
        .step_i  (cnt_step),
        .beat_o  (beat),
        .last_o  (last)
    );

    // The processor holds its address for the whole transfer, so its index
    // also selects the line being filled
    tag_memory i_tag_memory (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .write_i            (tag_write),
        .read_write_index_i (cpu_req_i.adr.f.index),
        .write_tag_i        (tag_entry),
        .read_index_i       (cpu_req_i.adr.f.index),
        .read_tag_o         (tag_rd)
    );

    data_memory i_data_memory (
        .clk_i         (clk_i),
        .write_i       (data_write),
        .write_sel_i   (data_sel),
        .write_index_i (cpu_req_i.adr.f.index),
        .write_word_i  (data_word),
        .write_data_i  (data_wdata),
        .read_index_i  (cpu_req_i.adr.f.index),
        .read_word_i   (cpu_req_i.adr.f.word),
        .read_data_o   (data_rd)
    );

endmodule

/* test/wb_mem_model.sv */
`timescale 1ns/1ns

module wb_mem_model (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  wb_pkg::wb_req_t req_i,
    output wb_pkg::wb_rsp_t rsp_o,
    // Wait states before the next ack, taken when a transfer starts
    input  logic [1:0]      ack_delay_i
);

    // Word addressed, covers the whole 16-bit byte space
    logic [31:0] mem_q [16384];
    logic        busy_q;
    logic [1:0]  wait_q;
    logic        take;
    logic [13:0] word_addr;

    // Every word starts with a pattern built from its full word address
    initial begin
        for (int i = 0; i < 16384; i++) begin
            mem_q[i] = {14'(i) ^ 14'h2b5, 2'b01, 14'(i), 2'b10};
        end
    end

    assign word_addr = req_i.adr.raw[15:2];

    // The transfer completes once its wait states have run out
    assign take = req_i.cyc && req_i.stb && !rsp_o.ack
        && (busy_q ? (wait_q == 2'd0) : (ack_delay_i == 2'd0));

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_o.ack <= 1'b0;
            busy_q    <= 1'b0;
            wait_q    <= '0;
        end else begin
            // Ack is a single cycle pulse
            rsp_o.ack <= take;
            if (take) begin
                busy_q <= 1'b0;
                if (req_i.we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (req_i.sel[b]) begin
                            mem_q[word_addr][8*b +: 8] <= req_i.dat[8*b +: 8];
                        end
                    end
                end else begin
                    rsp_o.dat <= mem_q[word_addr];
                end
            end else if (req_i.cyc && req_i.stb && !rsp_o.ack) begin
                busy_q <= 1'b1;
                wait_q <= busy_q ? wait_q - 2'd1 : ack_delay_i - 2'd1;
            end
        end
    end

endmodule

/* test/tb_wb_cache.sv */
`timescale 1ns/1ns

module tb_wb_cache;

    localparam int CLK_PERIOD = 100;
    localparam int RANDOM_TRANSFERS = 24;
    // The directed tests issue 12 transfers before the random run
    localparam int NUM_TRANSFERS = 12 + RANDOM_TRANSFERS;
    localparam int ACK_TIMEOUT = 100;

    logic            clk;
    logic            rst_n;
    wb_pkg::wb_req_t cpu_req;
    wb_pkg::wb_rsp_t cpu_rsp;
    wb_pkg::wb_req_t mem_req;
    wb_pkg::wb_rsp_t mem_rsp;
    logic [1:0]      ack_delay;

    logic [15:0] lfsr_state;
    int          mismatch_count;
    int          problem_count;

    // Expected memory contents and the line each cache index should hold
    logic [31:0] mirror [logic [13:0]];
    logic        ref_valid [cache_cfg_pkg::NUM_LINES];
    logic [7:0]  ref_tag [cache_cfg_pkg::NUM_LINES];

    // What the memory bus did during the last processor transfer
    wb_pkg::wb_req_t beats [$];
    int              last_beat_cycle;
    int              ack_cycle;
    logic            mem_seen;

    wb_cache_top i_dut (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .cpu_req_i (cpu_req),
        .cpu_rsp_o (cpu_rsp),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp)
    );

    wb_mem_model i_mem (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .req_i       (mem_req),
        .rsp_o       (mem_rsp),
        .ack_delay_i (ack_delay)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Allows 40 cycles per transfer plus the reset phase
    initial begin
        #((NUM_TRANSFERS * 40 + 10) * CLK_PERIOD);
        $display("Watchdog expired, the tests did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // Galois LFSR x^16 + x^14 + x^13 + x^11 + 1
    // It steps once for each bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hb400 : lfsr_state >> 1;
        end
        return value;
    endfunction

    // Mirrored word once written, otherwise the power-up pattern of the memory model
    function automatic logic [31:0] expected_word(input logic [15:0] addr);
        logic [13:0] a;
        a = addr[15:2];
        if (mirror.exists(a)) begin
            return mirror[a];
        end
        return {a ^ 14'h2b5, 2'b01, a, 2'b10};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        mismatch_count++;
    endtask

    task automatic report_problem(input string what);
        $display("Error at %0t ns: %s", $time, what);
        problem_count++;
    endtask

    // Runs one processor transfer and records every memory beat on the way
    task automatic bus_transfer(input logic we, input logic [15:0] addr, input logic [3:0] sel,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        int   cycles;
        logic done;
        beats.delete();
        last_beat_cycle = -1;
        mem_seen = 1'b0;
        cycles = 0;
        done = 1'b0;
        rdata = 'x;
        @(negedge clk);
        cpu_req.cyc = 1'b1;
        cpu_req.stb = 1'b1;
        cpu_req.we = we;
        cpu_req.adr.raw = addr;
        cpu_req.sel = sel;
        cpu_req.dat = wdata;
        while (!done && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            ack_delay = 2'(random_bits(2));
            if (mem_req.cyc) begin
                mem_seen = 1'b1;
            end
            if (mem_req.cyc && mem_req.stb && mem_rsp.ack) begin
                beats.push_back(mem_req);
                last_beat_cycle = cycles;
            end
            if (cpu_rsp.ack) begin
                rdata = cpu_rsp.dat;
                done = 1'b1;
            end
        end
        ack_cycle = cycles;
        if (!done) begin
            report_problem("processor transfer never got an ack");
        end
        // The request drops in the cycle after the ack
        @(negedge clk);
        cpu_req.cyc = 1'b0;
        cpu_req.stb = 1'b0;
    endtask

    // Predicts hit or miss from the reference tags, then checks data and bus traffic
    task automatic read_and_check(input logic [15:0] addr);
        cache_cfg_pkg::cache_addr_u split;
        cache_cfg_pkg::cache_addr_u beat_addr;
        logic                       hit;
        logic [31:0]                rdata;
        logic [31:0]                exp;
        split.raw = addr;
        hit = ref_valid[split.f.index] && (ref_tag[split.f.index] == split.f.tag);
        exp = expected_word(addr);
        bus_transfer(1'b0, addr, 4'hf, '0, rdata);
        if (rdata !== exp) report_mismatch("cpu_rsp_o.dat", rdata, exp);
        if (hit) begin
            if (mem_seen) report_problem("read hit started a memory cycle");
            if (ack_cycle != 1) report_problem("read hit ack missed the second request cycle");
        end else begin
            if (beats.size() != 4) report_mismatch("refill beat count", beats.size(), 4);
            beat_addr = split;
            beat_addr.f.byte_off = '0;
            for (int i = 0; i < beats.size(); i++) begin
                beat_addr.f.word = 2'(i);
                if (beats[i].adr.raw !== beat_addr.raw) begin
                    report_mismatch("mem_req_o.adr", beats[i].adr.raw, beat_addr.raw);
                end
                if (beats[i].we !== 1'b0) report_problem("refill beat has we set");
            end
            if (ack_cycle != last_beat_cycle + 1) begin
                report_problem("read miss ack did not follow the last refill beat");
            end
            ref_valid[split.f.index] = 1'b1;
            ref_tag[split.f.index] = split.f.tag;
        end
    endtask

    // A write goes out as exactly one memory beat and never allocates a line
    task automatic write_and_check(input logic [15:0] addr, input logic [3:0] sel,
                                   input logic [31:0] data);
        logic [31:0] rdata;
        logic [31:0] merged;
        bus_transfer(1'b1, addr, sel, data, rdata);
        if (beats.size() != 1) begin
            report_mismatch("write beat count", beats.size(), 1);
        end else begin
            if (beats[0].we !== 1'b1) report_problem("write-through beat has we clear");
            if (beats[0].adr.raw !== addr) begin
                report_mismatch("mem_req_o.adr", beats[0].adr.raw, addr);
            end
            if (beats[0].sel !== sel) report_mismatch("mem_req_o.sel", beats[0].sel, sel);
            if (beats[0].dat !== data) report_mismatch("mem_req_o.dat", beats[0].dat, data);
        end
        if (ack_cycle != last_beat_cycle + 1) begin
            report_problem("write ack did not follow the memory ack by one cycle");
        end
        merged = expected_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) merged[8*b +: 8] = data[8*b +: 8];
        end
        mirror[addr[15:2]] = merged;
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------

    task automatic reset_and_first_miss();
        if (cpu_rsp.ack !== 1'b0) report_mismatch("cpu_rsp_o.ack", cpu_rsp.ack, 0);
        if (mem_req.cyc !== 1'b0) report_mismatch("mem_req_o.cyc", mem_req.cyc, 0);
        if (mem_req.stb !== 1'b0) report_mismatch("mem_req_o.stb", mem_req.stb, 0);
        // Word 2 of line 1 still refills from word 0
        read_and_check(16'h3a18);
    endtask

    task automatic miss_each_word();
        // One fresh line per word position
        for (int w = 0; w < 4; w++) begin
            read_and_check({8'(8'h50 + w), 4'(4 + w), 2'(w), 2'b00});
        end
    endtask

    task automatic hit_same_line();
        read_and_check(16'h3a10);
        read_and_check(16'h3a14);
        read_and_check(16'h3a1c);
    endtask

    task automatic write_hit_merge();
        write_and_check(16'h3a18, 4'b0101, random_bits(32));
        read_and_check(16'h3a18);
    endtask

    task automatic write_miss_no_allocate();
        write_and_check(16'hc52c, 4'hf, random_bits(32));
        read_and_check(16'hc52c);
    endtask

    // Four tags share two indices, so lines keep getting evicted
    task automatic random_evictions();
        cache_cfg_pkg::cache_addr_u addr;
        logic [3:0]                 sel;
        logic [31:0]                data;
        for (int n = 0; n < RANDOM_TRANSFERS; n++) begin
            addr.f.tag = 8'h60 + 8'(random_bits(2));
            addr.f.index = random_bits(1) ? 4'h9 : 4'ha;
            addr.f.word = 2'(random_bits(2));
            addr.f.byte_off = '0;
            if (random_bits(2) == 0) begin
                sel = 4'(random_bits(4)) | 4'b0001;
                data = random_bits(32);
                write_and_check(addr.raw, sel, data);
            end else begin
                read_and_check(addr.raw);
            end
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        rst_n = 1'b0;
        cpu_req = '0;
        ack_delay = 2'd0;
        lfsr_state = 16'd99;
        mismatch_count = 0;
        problem_count = 0;
        mem_seen = 1'b0;
        for (int i = 0; i < cache_cfg_pkg::NUM_LINES; i++) begin
            ref_valid[i] = 1'b0;
            ref_tag[i] = '0;
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        reset_and_first_miss();
        miss_each_word();
        hit_same_line();
        write_hit_merge();
        write_miss_no_allocate();
        random_evictions();
        $display("Value mismatches: %0d, other failures: %0d", mismatch_count, problem_count);
        if (mismatch_count == 0 && problem_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* src.f */
hdl/cache_cfg_pkg.sv
hdl/wb_pkg.sv
hdl/tag_memory.sv
hdl/data_memory.sv
hdl/refill_counter.sv
hdl/cache_controller.sv
hdl/wb_cache_top.sv
test/wb_mem_model.sv
test/tb_wb_cache.sv
